// ==== source/xr_map_pkg.sv ====
// XR bus word and address types plus the address map, imported by the XR RTL and the testbench
`default_nettype none

package xr_map_pkg;

    // XR data word and XR address
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;

    // memory region bases, bits 15 to 13 pick the region
    localparam addr_t XR_COLOR_BASE = 16'hA000 - 16'h2000;
    localparam addr_t XR_TILE_BASE  = 16'hA000;

    // control register indices on the 7-bit register bus
    localparam logic [6:0] REG_CTRL       = 7'd0;
    localparam logic [6:0] REG_TILE_START = 7'd1;
    localparam logic [6:0] REG_RUN_LEN    = 7'd2;

    // REG_CTRL bit holding the fetch enable
    localparam int CTRL_FETCH_EN_BIT = 0;

    // bit 15 low means a control register access
    function automatic logic xr_is_reg(addr_t a);
        return (a[15] == 1'b0);
    endfunction

    function automatic logic xr_is_color(addr_t a);
        return (a[15:13] == XR_COLOR_BASE[15:13]);
    endfunction

    function automatic logic xr_is_tile(addr_t a);
        return (a[15:13] == XR_TILE_BASE[15:13]);
    endfunction

endpackage

`default_nettype wire

// ==== source/vid_pkg.sv ====
// pixel color type and default video memory sizes, imported by the video datapath and top level
`default_nettype none

package vid_pkg;

    // one 16-bit color entry, 4 bits per channel
    typedef struct packed {
        logic [3:0] a;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } argb_t;

    // default address widths of the color and tile memories
    localparam int DEF_COLOR_AW = 8;
    localparam int DEF_TILE_AW  = 10;

endpackage

`default_nettype wire

// ==== source/xr_port_if.sv ====
// one sel/ack XR access port, driven by a requester and answered by the memory arbiter
`default_nettype none
`timescale 1ns/1ps

interface xr_port_if
    import xr_map_pkg::*;
();

    logic  sel;
    logic  wr;
    addr_t addr;
    word_t wdata;
    // ack pulses for one cycle, rdata is valid with it on a read
    logic  ack;
    word_t rdata;

    modport requester (
        output sel, wr, addr, wdata,
        input  ack, rdata
    );

    modport arbiter (
        input  sel, wr, addr, wdata,
        output ack, rdata
    );

endinterface

`default_nettype wire

// ==== source/xr_dpram.sv ====
// one-read one-write block RAM with a registered read port, instantiated per XR memory region
`default_nettype none
`timescale 1ns/1ps

module xr_dpram #(
    parameter type data_t = logic [15:0],
    parameter int  AW     = 8
) (
    input  wire logic          clk,
    input  wire logic          rd_en_i,
    input  wire logic [AW-1:0] rd_addr_i,
    output      data_t         rd_data_o,
    input  wire logic          wr_en_i,
    input  wire logic [AW-1:0] wr_addr_i,
    input  wire data_t         wr_data_i
);

    data_t mem [0:(1 << AW) - 1];

    // output holds its last value until the next enabled read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/xrmem_arb.sv ====
// XR memory arbiter between the host port and video reads over the color and tile memories
`default_nettype none
`timescale 1ns/1ps

module xrmem_arb
    import xr_map_pkg::*;
    import vid_pkg::*;
#(
    parameter int COLOR_AW = DEF_COLOR_AW,
    parameter int TILE_AW  = DEF_TILE_AW
) (
    input  wire logic                clk,
    input  wire logic                reset_i,

    // host XR access port
    xr_port_if.arbiter               host,

    // control register bus
    output      logic                xreg_wr_o,
    output      logic [6:0]          xreg_addr_o,
    output      word_t               xreg_wdata_o,
    input  wire word_t               xreg_rdata_i,

    // video read ports, data one cycle after the read
    input  wire logic                vid_tile_rd_i,
    input  wire logic [TILE_AW-1:0]  vid_tile_addr_i,
    output      word_t               vid_tile_data_o,
    input  wire logic                vid_color_rd_i,
    input  wire logic [COLOR_AW-1:0] vid_color_addr_i,
    output      argb_t               vid_color_data_o
);

    // which source the pending host read data comes from
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_REG,
        SRC_COLOR,
        SRC_TILE
    } rd_src_e;

    logic                req;
    logic                is_reg;
    logic                is_color;
    logic                is_tile;
    logic                host_color_rd;
    logic                host_tile_rd;
    logic                ack_next;
    rd_src_e             src_next;
    rd_src_e             src_q;

    logic                color_rd_en;
    logic [COLOR_AW-1:0] color_rd_addr;
    argb_t               color_rd_data;
    logic                color_wr_en;
    logic                tile_rd_en;
    logic [TILE_AW-1:0]  tile_rd_addr;
    word_t               tile_rd_data;
    logic                tile_wr_en;

    // sel is ignored in the ack cycle so one access is served once
    assign req      = host.sel & ~host.ack;
    assign is_reg   = xr_is_reg(host.addr);
    assign is_color = xr_is_color(host.addr);
    assign is_tile  = xr_is_tile(host.addr);

    assign xreg_wr_o    = req & host.wr & is_reg;
    assign xreg_addr_o  = host.addr[6:0];
    assign xreg_wdata_o = host.wdata;

    // writes use the separate write port and are never held off
    assign color_wr_en = req & host.wr & is_color;
    assign tile_wr_en  = req & host.wr & is_tile;

    // video owns a read port whenever it reads, host reads wait for a free cycle
    assign host_color_rd = req & ~host.wr & is_color & ~vid_color_rd_i;
    assign host_tile_rd  = req & ~host.wr & is_tile & ~vid_tile_rd_i;

    assign color_rd_en   = vid_color_rd_i | host_color_rd;
    assign color_rd_addr = vid_color_rd_i ? vid_color_addr_i : host.addr[COLOR_AW-1:0];
    assign tile_rd_en    = vid_tile_rd_i | host_tile_rd;
    assign tile_rd_addr  = vid_tile_rd_i ? vid_tile_addr_i : host.addr[TILE_AW-1:0];

    assign vid_color_data_o = color_rd_data;
    assign vid_tile_data_o  = tile_rd_data;

    always_comb begin
        ack_next = 1'b0;
        src_next = src_q;
        if (req) begin
            if (host.wr) begin
                ack_next = 1'b1;
                src_next = SRC_NONE;
            end else if (is_reg) begin
                ack_next = 1'b1;
                src_next = SRC_REG;
            end else if (is_color) begin
                ack_next = host_color_rd;
                src_next = SRC_COLOR;
            end else if (is_tile) begin
                ack_next = host_tile_rd;
                src_next = SRC_TILE;
            end else begin
                // unmapped region acks at once and reads 0
                ack_next = 1'b1;
                src_next = SRC_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            host.ack <= 1'b0;
            src_q    <= SRC_NONE;
        end else begin
            host.ack <= ack_next;
            src_q    <= src_next;
        end
    end

    // register reads use the address still held in the ack cycle
    always_comb begin
        case (src_q)
            SRC_REG:   host.rdata = xreg_rdata_i;
            SRC_COLOR: host.rdata = word_t'(color_rd_data);
            SRC_TILE:  host.rdata = tile_rd_data;
            default:   host.rdata = '0;
        endcase
    end

    xr_dpram #(
        .data_t (argb_t),
        .AW     (COLOR_AW)
    ) colormem (
        .clk       (clk),
        .rd_en_i   (color_rd_en),
        .rd_addr_i (color_rd_addr),
        .rd_data_o (color_rd_data),
        .wr_en_i   (color_wr_en),
        .wr_addr_i (host.addr[COLOR_AW-1:0]),
        .wr_data_i (argb_t'(host.wdata))
    );

    xr_dpram #(
        .data_t (word_t),
        .AW     (TILE_AW)
    ) tilemem (
        .clk       (clk),
        .rd_en_i   (tile_rd_en),
        .rd_addr_i (tile_rd_addr),
        .rd_data_o (tile_rd_data),
        .wr_en_i   (tile_wr_en),
        .wr_addr_i (host.addr[TILE_AW-1:0]),
        .wr_data_i (host.wdata)
    );

endmodule

`default_nettype wire

// ==== source/xr_regs.sv ====
// control register file on the XR register bus, feeding the fetch enable and run setup to video
`default_nettype none
`timescale 1ns/1ps

module xr_regs
    import xr_map_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       xreg_wr_i,
    input  wire logic [6:0] xreg_addr_i,
    input  wire word_t      xreg_wdata_i,
    output      word_t      xreg_rdata_o,
    output      logic       fetch_en_o,
    output      word_t      tile_start_o,
    output      word_t      run_len_o
);

    logic  fetch_en_q;
    word_t tile_start_q;
    word_t run_len_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_en_q   <= 1'b0;
            tile_start_q <= '0;
            run_len_q    <= '0;
        end else if (xreg_wr_i) begin
            case (xreg_addr_i)
                REG_CTRL:       fetch_en_q   <= xreg_wdata_i[CTRL_FETCH_EN_BIT];
                REG_TILE_START: tile_start_q <= xreg_wdata_i;
                REG_RUN_LEN:    run_len_q    <= xreg_wdata_i;
                default:        ;
            endcase
        end
    end

    // unmapped indices read as 0
    always_comb begin
        xreg_rdata_o = '0;
        case (xreg_addr_i)
            REG_CTRL:       xreg_rdata_o[CTRL_FETCH_EN_BIT] = fetch_en_q;
            REG_TILE_START: xreg_rdata_o = tile_start_q;
            REG_RUN_LEN:    xreg_rdata_o = run_len_q;
            default:        ;
        endcase
    end

    assign fetch_en_o   = fetch_en_q;
    assign tile_start_o = tile_start_q;
    assign run_len_o    = run_len_q;

endmodule

`default_nettype wire

// ==== source/vid_fetch.sv ====
// video fetch unit, reads tile words then their colors and streams pixels over valid/ready
`default_nettype none
`timescale 1ns/1ps

module vid_fetch
    import xr_map_pkg::*;
    import vid_pkg::*;
#(
    parameter int COLOR_AW = DEF_COLOR_AW,
    parameter int TILE_AW  = DEF_TILE_AW
) (
    input  wire logic                clk,
    input  wire logic                reset_i,
    input  wire logic                fetch_en_i,
    input  wire word_t               tile_start_i,
    input  wire word_t               run_len_i,
    output      logic                tile_rd_o,
    output      logic [TILE_AW-1:0]  tile_addr_o,
    input  wire word_t               tile_data_i,
    output      logic                color_rd_o,
    output      logic [COLOR_AW-1:0] color_addr_o,
    input  wire argb_t               color_data_i,
    output      logic                pix_valid_o,
    input  wire logic                pix_ready_i,
    output      argb_t               pix_data_o
);

    word_t      run_pos;
    word_t      run_last;
    word_t      tile_idx;
    logic       issue;
    logic       s1_valid;
    logic       s2_valid;
    logic [2:0] in_use;
    logic [1:0] skid_cnt;
    logic       wr_ptr;
    logic       rd_ptr;
    logic       push;
    logic       pop;
    argb_t      skid_q [2];

    // a run length of 0 behaves as 1
    assign run_last = (run_len_i == '0) ? '0 : run_len_i - 16'd1;
    assign tile_idx = tile_start_i + run_pos;

    // credit check, pixels in flight plus buffered must stay within the two skid entries
    assign in_use = 3'(s1_valid) + 3'(s2_valid) + 3'(skid_cnt);
    assign issue  = fetch_en_i & (in_use < 3'd2);

    assign tile_rd_o    = issue;
    assign tile_addr_o  = tile_idx[TILE_AW-1:0];
    assign color_rd_o   = s1_valid;
    assign color_addr_o = tile_data_i[COLOR_AW-1:0];

    assign push        = s2_valid;
    assign pop         = pix_valid_o & pix_ready_i;
    assign pix_valid_o = (skid_cnt != 2'd0);
    assign pix_data_o  = skid_q[rd_ptr];

    // run position restarts whenever the enable is low
    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_pos <= '0;
        end else if (!fetch_en_i) begin
            run_pos <= '0;
        end else if (issue) begin
            run_pos <= (run_pos >= run_last) ? '0 : run_pos + 16'd1;
        end
    end

    // s1 marks tile data arriving, s2 marks color data arriving
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            skid_cnt <= 2'd0;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   skid_cnt <= skid_cnt + 2'd1;
                2'b01:   skid_cnt <= skid_cnt - 2'd1;
                default: ;
            endcase
        end
    end

    // a push never lands on the head entry, so the output stays put while stalled
    always_ff @(posedge clk) begin
        if (push) begin
            skid_q[wr_ptr] <= color_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/xr_video_top.sv ====
// top level of the tile video memory subsystem, host XR port in and pixel stream out
`default_nettype none
`timescale 1ns/1ps

module xr_video_top
    import xr_map_pkg::*;
    import vid_pkg::*;
#(
    parameter int COLOR_AW = DEF_COLOR_AW,
    parameter int TILE_AW  = DEF_TILE_AW
) (
    input  wire logic  clk,
    input  wire logic  reset_i,

    // host XR port
    input  wire logic  host_sel_i,
    input  wire logic  host_wr_i,
    input  wire addr_t host_addr_i,
    input  wire word_t host_data_i,
    output      logic  host_ack_o,
    output      word_t host_data_o,

    // pixel stream
    output      logic  pix_valid_o,
    output      argb_t pix_data_o,
    input  wire logic  pix_ready_i
);

    logic                xreg_wr;
    logic [6:0]          xreg_addr;
    word_t               xreg_wdata;
    word_t               xreg_rdata;
    logic                fetch_en;
    word_t               tile_start;
    word_t               run_len;
    logic                tile_rd;
    logic [TILE_AW-1:0]  tile_addr;
    word_t               tile_data;
    logic                color_rd;
    logic [COLOR_AW-1:0] color_addr;
    argb_t               color_data;

    xr_port_if host_xr ();

    // host pins act as the requester side of host_xr
    assign host_xr.sel   = host_sel_i;
    assign host_xr.wr    = host_wr_i;
    assign host_xr.addr  = host_addr_i;
    assign host_xr.wdata = host_data_i;
    assign host_ack_o    = host_xr.ack;
    assign host_data_o   = host_xr.rdata;

    xrmem_arb #(
        .COLOR_AW (COLOR_AW),
        .TILE_AW  (TILE_AW)
    ) u_arb (
        .clk              (clk),
        .reset_i          (reset_i),
        .host             (host_xr),
        .xreg_wr_o        (xreg_wr),
        .xreg_addr_o      (xreg_addr),
        .xreg_wdata_o     (xreg_wdata),
        .xreg_rdata_i     (xreg_rdata),
        .vid_tile_rd_i    (tile_rd),
        .vid_tile_addr_i  (tile_addr),
        .vid_tile_data_o  (tile_data),
        .vid_color_rd_i   (color_rd),
        .vid_color_addr_i (color_addr),
        .vid_color_data_o (color_data)
    );

    xr_regs u_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .xreg_wr_i    (xreg_wr),
        .xreg_addr_i  (xreg_addr),
        .xreg_wdata_i (xreg_wdata),
        .xreg_rdata_o (xreg_rdata),
        .fetch_en_o   (fetch_en),
        .tile_start_o (tile_start),
        .run_len_o    (run_len)
    );

    vid_fetch #(
        .COLOR_AW (COLOR_AW),
        .TILE_AW  (TILE_AW)
    ) u_fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_en_i   (fetch_en),
        .tile_start_i (tile_start),
        .run_len_i    (run_len),
        .tile_rd_o    (tile_rd),
        .tile_addr_o  (tile_addr),
        .tile_data_i  (tile_data),
        .color_rd_o   (color_rd),
        .color_addr_o (color_addr),
        .color_data_i (color_data),
        .pix_valid_o  (pix_valid_o),
        .pix_ready_i  (pix_ready_i),
        .pix_data_o   (pix_data_o)
    );

endmodule

`default_nettype wire

// ==== test/xr_video_tb.sv ====
// testbench for xr_video_top, applies a table of host XR accesses and checks the pixel stream
`default_nettype none
`timescale 1ns/1ps

module xr_video_tb
    import xr_map_pkg::*;
    import vid_pkg::*;
();

    localparam int COLOR_AW   = DEF_COLOR_AW;
    localparam int TILE_AW    = DEF_TILE_AW;
    localparam int TILE_N     = 1 << TILE_AW;
    localparam int COLOR_N    = 1 << COLOR_AW;
    localparam int RUN1_START = TILE_N - 2;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_PIXELS,
        OP_IDLE
    } op_e;

    // read steps carry the expected word in data, pixel and idle steps a count in addr
    typedef struct packed {
        op_e   op;
        addr_t addr;
        word_t data;
    } step_t;

    logic  clk         = 1'b0;
    logic  reset_i     = 1'b1;
    logic  host_sel_i  = 1'b0;
    logic  host_wr_i   = 1'b0;
    addr_t host_addr_i = '0;
    word_t host_data_i = '0;
    logic  host_ack_o;
    word_t host_data_o;
    logic  pix_valid_o;
    argb_t pix_data_o;
    logic  pix_ready_i = 1'b0;

    step_t steps [$];
    word_t tile_model [TILE_N];
    argb_t color_model [COLOR_N];
    word_t reg_model [128];
    int    exp_pixels   = 0;
    int    watch_cycles = 0;
    // live run setup followed as the table is applied
    word_t cfg_start    = '0;
    word_t cfg_len      = '0;
    logic  started      = 1'b0;
    int    epoch_start  = 0;
    int    pix_total    = 0;
    logic  held         = 1'b0;
    argb_t held_data    = '0;

    xr_video_top uut (
        .clk         (clk),
        .reset_i     (reset_i),
        .host_sel_i  (host_sel_i),
        .host_wr_i   (host_wr_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .host_ack_o  (host_ack_o),
        .host_data_o (host_data_o),
        .pix_valid_o (pix_valid_o),
        .pix_data_o  (pix_data_o),
        .pix_ready_i (pix_ready_i)
    );

    always #2 clk = ~clk;

    // display side stalls about a third of the time
    always @(posedge clk) begin
        if (reset_i) begin
            pix_ready_i <= 1'b0;
        end else begin
            pix_ready_i <= (($urandom % 3) != 0);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s read %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_pixel(input int n, input argb_t got, input argb_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: pixel %0d is %h, expected %h",
                                $time, n, got, exp));
        end
    endtask

    // pixel n shows the color picked by tile start + (n mod run length)
    function automatic argb_t expected_pixel(input int n);
        int    len;
        word_t tile;
        len  = (cfg_len == '0) ? 1 : int'(cfg_len);
        tile = tile_model[(int'(cfg_start) + n % len) % TILE_N];
        return color_model[tile[COLOR_AW-1:0]];
    endfunction

    function automatic word_t model_read(input addr_t a);
        word_t tile;
        if (a[15] == 1'b0) begin
            return reg_model[a[6:0]];
        end else if (a[15:13] == XR_COLOR_BASE[15:13]) begin
            return word_t'(color_model[a[COLOR_AW-1:0]]);
        end
        tile = tile_model[a[TILE_AW-1:0]];
        return tile;
    endfunction

    task automatic push_step(input op_e op, input addr_t a, input word_t d);
        step_t st;
        st.op   = op;
        st.addr = a;
        st.data = d;
        steps.push_back(st);
        if (op == OP_PIXELS) begin
            exp_pixels += int'(a);
        end
    endtask

    task automatic add_write(input addr_t a, input word_t d);
        push_step(OP_WRITE, a, d);
        if (a[15] == 1'b0) begin
            case (a[6:0])
                REG_CTRL:       reg_model[a[6:0]] = {15'd0, d[0]};
                REG_TILE_START: reg_model[a[6:0]] = d;
                REG_RUN_LEN:    reg_model[a[6:0]] = d;
                default:        ;
            endcase
        end else if (a[15:13] == XR_COLOR_BASE[15:13]) begin
            color_model[a[COLOR_AW-1:0]] = argb_t'(d);
        end else if (a[15:13] == XR_TILE_BASE[15:13]) begin
            tile_model[a[TILE_AW-1:0]] = d;
        end
    endtask

    task automatic add_read(input addr_t a);
        push_step(OP_READ, a, model_read(a));
    endtask

    // each run tile gets its own color entry in an 8 entry slot above color_lo
    task automatic add_run(input int start, input int len, input int color_lo);
        word_t tw;
        int    c;
        for (int k = 0; k < len; k++) begin
            c = color_lo + k * 8 + int'($urandom % 8);
            add_write(XR_COLOR_BASE + addr_t'(c), word_t'($urandom));
            tw = word_t'($urandom);
            tw[COLOR_AW-1:0] = COLOR_AW'(c);
            add_write(XR_TILE_BASE + addr_t'((start + k) % TILE_N), tw);
        end
        add_write(addr_t'(REG_TILE_START), word_t'(start));
        add_write(addr_t'(REG_RUN_LEN), word_t'(len));
        add_write(addr_t'(REG_CTRL), 16'h0001);
    endtask

    task automatic build_table();
        addr_t rnd_addr [16];
        word_t tw;
        foreach (reg_model[i]) reg_model[i] = '0;
        add_read(addr_t'(REG_CTRL));
        add_read(addr_t'(REG_TILE_START));
        add_read(addr_t'(REG_RUN_LEN));
        add_write(16'h0005, word_t'($urandom));
        add_read(16'h0005);
        add_write(addr_t'(REG_TILE_START), 16'h1234);
        add_write(addr_t'(REG_RUN_LEN), 16'h0007);
        add_write(addr_t'(REG_CTRL), 16'hFFFE);
        add_read(addr_t'(REG_CTRL));
        add_read(addr_t'(REG_TILE_START));
        add_read(addr_t'(REG_RUN_LEN));
        // random memory words with the fetch idle and upper offset bits left random
        for (int i = 0; i < 16; i++) begin
            rnd_addr[i] = (i < 8) ? XR_COLOR_BASE : XR_TILE_BASE;
            rnd_addr[i] = rnd_addr[i] | addr_t'($urandom & 32'h1FFF);
            add_write(rnd_addr[i], word_t'($urandom));
        end
        foreach (rnd_addr[i]) add_read(rnd_addr[i]);
        // first run wraps past the top of tile memory
        add_run(RUN1_START, 5, 0);
        push_step(OP_PIXELS, 16'd12, '0);
        for (int k = 0; k < 5; k++) begin
            tw = tile_model[(RUN1_START + k) % TILE_N];
            add_read(XR_TILE_BASE + addr_t'((RUN1_START + k) % TILE_N));
            add_read(XR_COLOR_BASE + addr_t'(tw[COLOR_AW-1:0]));
        end
        // upper half of color memory is never used by a run
        for (int i = 0; i < 4; i++) begin
            rnd_addr[i] = XR_COLOR_BASE + addr_t'(COLOR_N / 2 + int'($urandom % 128));
            add_write(rnd_addr[i], word_t'($urandom));
            add_read(rnd_addr[i]);
        end
        push_step(OP_PIXELS, 16'd24, '0);
        add_write(addr_t'(REG_CTRL), 16'h0000);
        push_step(OP_IDLE, 16'd16, '0);
        add_run(300, 3, 64);
        push_step(OP_PIXELS, 16'd9, '0);
        add_read(addr_t'(REG_CTRL));
    endtask

    // one XR access holding sel until ack and dropping it in the following cycle
    task automatic host_access(input logic wr, input addr_t a, input word_t d,
                               output word_t rd, output int lat);
        @(posedge clk);
        host_sel_i  <= 1'b1;
        host_wr_i   <= wr;
        host_addr_i <= a;
        host_data_i <= d;
        lat = 0;
        @(negedge clk);
        while (!host_ack_o) begin
            lat++;
            @(negedge clk);
        end
        rd = host_data_o;
        @(posedge clk);
        host_sel_i <= 1'b0;
        host_wr_i  <= 1'b0;
    endtask

    task automatic run_step(input step_t st);
        word_t rd;
        int    lat;
        int    seen;
        case (st.op)
            OP_WRITE: begin
                if (st.addr[15] == 1'b0) begin
                    if (st.addr[6:0] == REG_TILE_START) cfg_start = st.data;
                    if (st.addr[6:0] == REG_RUN_LEN) cfg_len = st.data;
                    if (st.addr[6:0] == REG_CTRL && st.data[0]) begin
                        epoch_start = pix_total;
                        started     = 1'b1;
                    end
                end
                host_access(1'b1, st.addr, st.data, rd, lat);
                if (lat != 1) begin
                    abort_run($sformatf("write to %h acked after %0d cycles instead of 1",
                                        st.addr, lat));
                end
            end
            OP_READ: begin
                host_access(1'b0, st.addr, '0, rd, lat);
                if (st.addr[15] == 1'b0 && lat != 1) begin
                    abort_run($sformatf("register read %h acked after %0d cycles instead of 1",
                                        st.addr, lat));
                end
                check_word($sformatf("address %h", st.addr), rd, st.data);
            end
            OP_PIXELS: begin
                while (pix_total - epoch_start < int'(st.addr)) @(negedge clk);
            end
            default: begin
                repeat (int'(st.addr)) @(negedge clk);
                seen = pix_total;
                repeat (int'(st.addr)) @(negedge clk);
                if (pix_total != seen || pix_valid_o) begin
                    abort_run("pixels kept coming after the fetch was disabled");
                end
            end
        endcase
    endtask

    // display model and scoreboard sampled half a cycle after the edge
    always @(negedge clk) begin
        if (host_ack_o && !host_sel_i) begin
            abort_run("host ack raised with no access pending");
        end
        if (pix_valid_o && !started) begin
            abort_run("pixel valid raised before the fetch was ever enabled");
        end
        if (held && (!pix_valid_o || pix_data_o !== held_data)) begin
            abort_run("pixel output changed while the display was stalling it");
        end
        if (pix_valid_o && pix_ready_i) begin
            check_pixel(pix_total - epoch_start, pix_data_o,
                        expected_pixel(pix_total - epoch_start));
            pix_total = pix_total + 1;
            held      = 1'b0;
        end else begin
            held      = pix_valid_o;
            held_data = pix_data_o;
        end
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        abort_run("timeout: no ack or pixels stalled");
    end

    initial begin
        void'($urandom(32'h8784_fb56));
        build_table();
        watch_cycles = steps.size() * 40 + exp_pixels * 12;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        foreach (steps[i]) run_step(steps[i]);
        repeat (4) @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== xr_video_top.f ====
source/xr_map_pkg.sv
source/vid_pkg.sv
source/xr_port_if.sv
source/xr_dpram.sv
source/xrmem_arb.sv
source/xr_regs.sv
source/vid_fetch.sv
source/xr_video_top.sv
test/xr_video_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it, exit status is the test result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module xr_video_tb \
    -f xr_video_top.f -o xr_video_sim \
    && ./obj_dir/xr_video_sim \
    || exit 1
